// File: src/rename_pkg.sv
// Types for an RV32 front end with 32 architectural and at most 64 physical registers
`default_nettype none

package rename_pkg;

    typedef logic [31:0] inst_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  arch_reg_t;
    // Six bits cover up to 64 physical registers
    typedef logic [5:0]  phys_tag_t;

    localparam int ARCH_REGS = 32;

    typedef enum logic [1:0] {
        OPA_IS_RS1  = 2'h0,
        OPA_IS_PC   = 2'h1,
        OPA_IS_ZERO = 2'h2
    } opa_sel_e;

    typedef enum logic [2:0] {
        OPB_IS_RS2   = 3'h0,
        OPB_IS_I_IMM = 3'h1,
        OPB_IS_S_IMM = 3'h2,
        OPB_IS_B_IMM = 3'h3,
        OPB_IS_U_IMM = 3'h4,
        OPB_IS_J_IMM = 3'h5
    } opb_sel_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'h0,
        ALU_SUB    = 4'h1,
        ALU_SLT    = 4'h2,
        ALU_SLTU   = 4'h3,
        ALU_AND    = 4'h4,
        ALU_OR     = 4'h5,
        ALU_XOR    = 4'h6,
        ALU_SLL    = 4'h7,
        ALU_SRL    = 4'h8,
        ALU_SRA    = 4'h9,
        ALU_MUL    = 4'ha,
        ALU_MULH   = 4'hb,
        ALU_MULHSU = 4'hc,
        ALU_MULHU  = 4'hd
    } alu_func_e;

endpackage

`default_nettype wire

// File: src/rv32_decoder.sv
// RV32I plus MUL* only; divides, fences, ECALL and immediate CSR forms decode as illegal
`timescale 1ns/1ps
`default_nettype none

module rv32_decoder (
    input  rename_pkg::inst_t     inst,
    input  logic                  valid,
    output rename_pkg::opa_sel_e  opa_select,
    output rename_pkg::opb_sel_e  opb_select,
    output rename_pkg::alu_func_e alu_func,
    output logic                  has_dest, rd_mem, wr_mem,
    output logic                  cond_branch, uncond_branch,
    output logic                  csr_op, halt, illegal
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_lui, is_auipc, is_jal, is_jalr, is_branch, is_load, is_store;
    logic       is_op_imm, is_op, is_mul, is_csr, is_wfi;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    //////////////////////////////////////////////////////////////////////
    // Instruction classes, each with its funct3/funct7 already checked
    //////////////////////////////////////////////////////////////////////
    assign is_lui    = opcode == 7'b0110111;
    assign is_auipc  = opcode == 7'b0010111;
    assign is_jal    = opcode == 7'b1101111;
    assign is_jalr   = opcode == 7'b1100111 && funct3 == 3'b000;
    assign is_branch = opcode == 7'b1100011 && funct3[2:1] != 2'b01;
    assign is_load   = opcode == 7'b0000011 && funct3 != 3'b011 && funct3[2:1] != 2'b11;
    assign is_store  = opcode == 7'b0100011 && !funct3[2] && funct3[1:0] != 2'b11;
    // Immediate shifts keep funct7 at zero, except SRAI
    assign is_op_imm = opcode == 7'b0010011 &&
                       (funct3[1:0] != 2'b01 || funct7 == 7'b0000000 ||
                        (funct3 == 3'b101 && funct7 == 7'b0100000));
    assign is_op     = opcode == 7'b0110011 &&
                       (funct7 == 7'b0000000 ||
                        (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
    assign is_mul    = opcode == 7'b0110011 && funct7 == 7'b0000001 && !funct3[2];
    // CSRRW, CSRRS and CSRRC
    assign is_csr    = opcode == 7'b1110011 && funct3 != 3'b000 && !funct3[2];
    assign is_wfi    = inst == 32'h1050_0073;

    assign has_dest      = valid && (is_lui || is_auipc || is_jal || is_jalr || is_load ||
                                     is_op_imm || is_op || is_mul);
    assign rd_mem        = valid && is_load;
    assign wr_mem        = valid && is_store;
    assign cond_branch   = valid && is_branch;
    assign uncond_branch = valid && (is_jal || is_jalr);
    assign csr_op        = valid && is_csr;
    assign halt          = valid && is_wfi;
    // Anything matching no class above
    assign illegal = valid && !(has_dest || wr_mem || cond_branch || csr_op || halt);

    // Operand muxes, NOP settings when not valid
    always_comb begin
        opa_select = rename_pkg::OPA_IS_RS1;
        opb_select = rename_pkg::OPB_IS_RS2;
        if (valid) begin
            if (is_lui) begin
                opa_select = rename_pkg::OPA_IS_ZERO;
            end else if (is_auipc || is_jal || is_branch) begin
                opa_select = rename_pkg::OPA_IS_PC;
            end
            if (is_lui || is_auipc) begin
                opb_select = rename_pkg::OPB_IS_U_IMM;
            end else if (is_jal) begin
                opb_select = rename_pkg::OPB_IS_J_IMM;
            end else if (is_branch) begin
                opb_select = rename_pkg::OPB_IS_B_IMM;
            end else if (is_store) begin
                opb_select = rename_pkg::OPB_IS_S_IMM;
            end else if (is_jalr || is_load || is_op_imm) begin
                opb_select = rename_pkg::OPB_IS_I_IMM;
            end
        end
    end

    always_comb begin
        alu_func = rename_pkg::ALU_ADD;
        if (valid && is_mul) begin
            case (funct3[1:0])
                2'b00:   alu_func = rename_pkg::ALU_MUL;
                2'b01:   alu_func = rename_pkg::ALU_MULH;
                2'b10:   alu_func = rename_pkg::ALU_MULHSU;
                default: alu_func = rename_pkg::ALU_MULHU;
            endcase
        end else if (valid && (is_op || is_op_imm)) begin
            case (funct3)
                3'b001:  alu_func = rename_pkg::ALU_SLL;
                3'b010:  alu_func = rename_pkg::ALU_SLT;
                3'b011:  alu_func = rename_pkg::ALU_SLTU;
                3'b100:  alu_func = rename_pkg::ALU_XOR;
                3'b101:  alu_func = rename_pkg::ALU_SRL;
                3'b110:  alu_func = rename_pkg::ALU_OR;
                3'b111:  alu_func = rename_pkg::ALU_AND;
                default: alu_func = rename_pkg::ALU_ADD;
            endcase
            // Bit 30 picks SRA, and SUB in the register form only
            if (funct7[5] && funct3 == 3'b101) begin
                alu_func = rename_pkg::ALU_SRA;
            end else if (funct7[5] && is_op) begin
                alu_func = rename_pkg::ALU_SUB;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/decode_stage.sv
// One-entry decode register with valid/ready handshake and full throughput
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  rename_pkg::inst_t     inst,
    input  rename_pkg::addr_t     pc,
    output logic                  dec_valid,
    input  logic                  dec_ready,
    output rename_pkg::inst_t     dec_inst,
    output rename_pkg::addr_t     dec_pc,
    output rename_pkg::opa_sel_e  dec_opa_select,
    output rename_pkg::opb_sel_e  dec_opb_select,
    output rename_pkg::alu_func_e dec_alu_func,
    output logic                  dec_has_dest, dec_rd_mem, dec_wr_mem,
    output logic                  dec_cond_branch, dec_uncond_branch,
    output logic                  dec_csr_op, dec_halt, dec_illegal
);
    rename_pkg::opa_sel_e  opa_select;
    rename_pkg::opb_sel_e  opb_select;
    rename_pkg::alu_func_e alu_func;
    logic                  has_dest, rd_mem, wr_mem, cond_branch, uncond_branch;
    logic                  csr_op, halt, illegal;
    logic                  accept;

    rv32_decoder i_rv32_decoder (
        .valid (in_valid),
        .*
    );

    // Accept when empty or when the slot drains this cycle
    assign in_ready = !dec_valid || dec_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else if (accept) begin
            dec_valid <= 1'b1;
        end else if (dec_ready) begin
            dec_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec_inst          <= inst;
            dec_pc            <= pc;
            dec_opa_select    <= opa_select;
            dec_opb_select    <= opb_select;
            dec_alu_func      <= alu_func;
            // An illegal word never claims a destination
            dec_has_dest      <= has_dest && !illegal;
            dec_rd_mem        <= rd_mem;
            dec_wr_mem        <= wr_mem;
            dec_cond_branch   <= cond_branch;
            dec_uncond_branch <= uncond_branch;
            dec_csr_op        <= csr_op;
            dec_halt          <= halt;
            dec_illegal       <= illegal;
        end
    end

endmodule

`default_nettype wire

// File: src/map_table.sv
// Entries reset to the identity mapping and x0 is never remapped
`timescale 1ns/1ps
`default_nettype none

module map_table (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rename_pkg::arch_reg_t rs1,
    input  rename_pkg::arch_reg_t rs2,
    input  rename_pkg::arch_reg_t rd,
    output rename_pkg::phys_tag_t src1_tag,
    output rename_pkg::phys_tag_t src2_tag,
    output rename_pkg::phys_tag_t old_tag,
    input  logic                  write_en,
    input  rename_pkg::phys_tag_t write_tag
);
    rename_pkg::phys_tag_t tags [rename_pkg::ARCH_REGS];

    // Reads see the table before this cycle's write
    assign src1_tag = tags[rs1];
    assign src2_tag = tags[rs2];
    assign old_tag  = tags[rd];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
                tags[i] <= rename_pkg::phys_tag_t'(i);
            end
        end else if (write_en && rd != '0) begin
            tags[rd] <= write_tag;
        end
    end

endmodule

`default_nettype wire

// File: src/free_list.sv
// Holds PHYS_REGS-32 tags and has no overflow guard, so only popped tags may come back
`timescale 1ns/1ps
`default_nettype none

module free_list #(
    parameter int PHYS_REGS = 64
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pop,
    output rename_pkg::phys_tag_t free_tag,
    output logic                  empty,
    input  logic                  push,
    input  rename_pkg::phys_tag_t push_tag
);
    localparam int DEPTH = PHYS_REGS - rename_pkg::ARCH_REGS;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    rename_pkg::phys_tag_t slots [DEPTH];
    logic [PTR_W-1:0]      head;
    logic [PTR_W-1:0]      tail;
    logic [CNT_W-1:0]      count;
    logic                  do_pop;

    // Depth need not be a power of two
    function automatic logic [PTR_W-1:0] step(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign empty    = count == '0;
    assign do_pop   = pop && !empty;
    assign free_tag = slots[head];

    // Starts full, so tail wraps back onto head
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= CNT_W'(DEPTH);
        end else begin
            if (do_pop) begin
                head <= step(head);
            end
            if (push) begin
                tail <= step(tail);
            end
            count <= count + CNT_W'(push) - CNT_W'(do_pop);
        end
    end

    // Preloaded with tags 32 and up, lowest first
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                slots[i] <= rename_pkg::phys_tag_t'(rename_pkg::ARCH_REGS + i);
            end
        end else if (push) begin
            slots[tail] <= push_tag;
        end
    end

endmodule

`default_nettype wire

// File: src/rename_stage.sv
// Stalls while a tag is needed and the free list is empty; no checkpoint or recovery
`timescale 1ns/1ps
`default_nettype none

module rename_stage #(
    parameter int PHYS_REGS = 64
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  dec_valid,
    output logic                  dec_ready,
    input  rename_pkg::inst_t     dec_inst,
    input  rename_pkg::addr_t     dec_pc,
    input  rename_pkg::opa_sel_e  dec_opa_select,
    input  rename_pkg::opb_sel_e  dec_opb_select,
    input  rename_pkg::alu_func_e dec_alu_func,
    input  logic                  dec_has_dest, dec_rd_mem, dec_wr_mem,
    input  logic                  dec_cond_branch, dec_uncond_branch,
    input  logic                  dec_csr_op, dec_halt, dec_illegal,
    input  logic                  commit_valid,
    input  rename_pkg::phys_tag_t commit_tag,
    output logic                  uop_valid,
    input  logic                  uop_ready,
    output rename_pkg::addr_t     uop_pc,
    output rename_pkg::alu_func_e uop_alu_func,
    output rename_pkg::opa_sel_e  uop_opa_select,
    output rename_pkg::opb_sel_e  uop_opb_select,
    output logic                  uop_rd_mem, uop_wr_mem,
    output logic                  uop_cond_branch, uop_uncond_branch,
    output logic                  uop_csr_op, uop_halt, uop_illegal, uop_has_dest,
    output rename_pkg::phys_tag_t uop_src1_tag, uop_src2_tag, uop_dest_tag, uop_old_tag
);
    rename_pkg::arch_reg_t rs1_idx, rs2_idx, rd_idx;
    rename_pkg::phys_tag_t src1_tag, src2_tag, old_tag, free_tag;
    logic                  need_rs1, need_rs2, need_tag, fl_empty, accept, alloc;

    // Unneeded sources read x0 and so get tag 0
    assign need_rs1 = dec_opa_select == rename_pkg::OPA_IS_RS1 || dec_cond_branch;
    assign need_rs2 = dec_opb_select inside {rename_pkg::OPB_IS_RS2, rename_pkg::OPB_IS_B_IMM,
                                             rename_pkg::OPB_IS_S_IMM};
    assign rs1_idx  = need_rs1 ? dec_inst[19:15] : '0;
    assign rs2_idx  = need_rs2 ? dec_inst[24:20] : '0;
    assign rd_idx   = dec_inst[11:7];
    assign need_tag = dec_valid && dec_has_dest && rd_idx != '0;

    assign dec_ready = (!uop_valid || uop_ready) && (!need_tag || !fl_empty);
    assign accept    = dec_valid && dec_ready;
    assign alloc     = accept && need_tag;

    map_table i_map_table (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs1       (rs1_idx),
        .rs2       (rs2_idx),
        .rd        (rd_idx),
        .src1_tag  (src1_tag),
        .src2_tag  (src2_tag),
        .old_tag   (old_tag),
        .write_en  (alloc),
        .write_tag (free_tag)
    );

    free_list #(.PHYS_REGS(PHYS_REGS)) i_free_list (
        .clk      (clk),
        .rst_n    (rst_n),
        .pop      (alloc),
        .free_tag (free_tag),
        .empty    (fl_empty),
        .push     (commit_valid),
        .push_tag (commit_tag)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            uop_valid <= 1'b0;
        end else if (accept) begin
            uop_valid <= 1'b1;
        end else if (uop_ready) begin
            uop_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            uop_pc            <= dec_pc;
            uop_alu_func      <= dec_alu_func;
            uop_opa_select    <= dec_opa_select;
            uop_opb_select    <= dec_opb_select;
            uop_rd_mem        <= dec_rd_mem;
            uop_wr_mem        <= dec_wr_mem;
            uop_cond_branch   <= dec_cond_branch;
            uop_uncond_branch <= dec_uncond_branch;
            uop_csr_op        <= dec_csr_op;
            uop_halt          <= dec_halt;
            uop_illegal       <= dec_illegal;
            uop_has_dest      <= need_tag;
            uop_src1_tag      <= src1_tag;
            uop_src2_tag      <= src2_tag;
            uop_dest_tag      <= need_tag ? free_tag : '0;
            uop_old_tag       <= need_tag ? old_tag : '0;
        end
    end

endmodule

`default_nettype wire

// File: src/rename_top.sv
// Two-cycle decode and rename front end; PHYS_REGS must lie in 33 to 64
`timescale 1ns/1ps
`default_nettype none

module rename_top #(
    parameter int PHYS_REGS = 64
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  inst_valid,
    output logic                  inst_ready,
    input  rename_pkg::inst_t     inst,
    input  rename_pkg::addr_t     pc,
    input  logic                  commit_valid,
    input  rename_pkg::phys_tag_t commit_tag,
    output logic                  uop_valid,
    input  logic                  uop_ready,
    output rename_pkg::addr_t     uop_pc,
    output rename_pkg::alu_func_e uop_alu_func,
    output rename_pkg::opa_sel_e  uop_opa_select,
    output rename_pkg::opb_sel_e  uop_opb_select,
    output logic                  uop_rd_mem, uop_wr_mem,
    output logic                  uop_cond_branch, uop_uncond_branch,
    output logic                  uop_csr_op, uop_halt, uop_illegal, uop_has_dest,
    output rename_pkg::phys_tag_t uop_src1_tag, uop_src2_tag, uop_dest_tag, uop_old_tag
);
    //////////////////////////////////////////////////////////////////////
    // Decode to rename link
    //////////////////////////////////////////////////////////////////////
    logic                  dec_valid, dec_ready;
    rename_pkg::inst_t     dec_inst;
    rename_pkg::addr_t     dec_pc;
    rename_pkg::opa_sel_e  dec_opa_select;
    rename_pkg::opb_sel_e  dec_opb_select;
    rename_pkg::alu_func_e dec_alu_func;
    logic                  dec_has_dest, dec_rd_mem, dec_wr_mem;
    logic                  dec_cond_branch, dec_uncond_branch;
    logic                  dec_csr_op, dec_halt, dec_illegal;

    decode_stage i_decode_stage (
        .in_valid (inst_valid),
        .in_ready (inst_ready),
        .*
    );

    rename_stage #(.PHYS_REGS(PHYS_REGS)) i_rename_stage (
        .*
    );

endmodule

`default_nettype wire

// File: test/tb_rename.sv
// Run from the project root so test/rename_stim.txt is found; tag checks assume PHYS_REGS of 40
`timescale 1ns/1ps
`default_nettype none

module tb_rename;

    localparam int PHYS_REGS = 40;

    logic                  clk;
    logic                  rst_n;
    logic                  inst_valid;
    logic                  inst_ready;
    rename_pkg::inst_t     inst;
    rename_pkg::addr_t     pc;
    logic                  commit_valid;
    rename_pkg::phys_tag_t commit_tag;
    logic                  uop_valid;
    logic                  uop_ready;
    rename_pkg::addr_t     uop_pc;
    rename_pkg::alu_func_e uop_alu_func;
    rename_pkg::opa_sel_e  uop_opa_select;
    rename_pkg::opb_sel_e  uop_opb_select;
    logic                  uop_rd_mem, uop_wr_mem, uop_cond_branch, uop_uncond_branch;
    logic                  uop_csr_op, uop_halt, uop_illegal, uop_has_dest;
    rename_pkg::phys_tag_t uop_src1_tag, uop_src2_tag, uop_dest_tag, uop_old_tag;

    // Stimulus table with one entry per stim line
    byte         s_kind  [$];
    logic [31:0] s_inst  [$];
    logic [31:0] s_pc    [$];
    logic [7:0]  s_opa   [$];
    logic [7:0]  s_opb   [$];
    logic [7:0]  s_alu   [$];
    logic [7:0]  s_flags [$];
    int          s_k     [$];
    int          num_inst = 0;

    // Reference model of map table and free list
    rename_pkg::phys_tag_t model_map [rename_pkg::ARCH_REGS];
    rename_pkg::phys_tag_t model_free [$];
    rename_pkg::phys_tag_t old_seen [$];
    int                    pending [$];
    int                    received = 0;
    int                    cycles = 0;
    int                    limit = 1000000;
    integer                seed = 32'h2000_2949;

    rename_top #(.PHYS_REGS(PHYS_REGS)) i_rename_top (
        .clk               (clk),
        .rst_n             (rst_n),
        .inst_valid        (inst_valid),
        .inst_ready        (inst_ready),
        .inst              (inst),
        .pc                (pc),
        .commit_valid      (commit_valid),
        .commit_tag        (commit_tag),
        .uop_valid         (uop_valid),
        .uop_ready         (uop_ready),
        .uop_pc            (uop_pc),
        .uop_alu_func      (uop_alu_func),
        .uop_opa_select    (uop_opa_select),
        .uop_opb_select    (uop_opb_select),
        .uop_rd_mem        (uop_rd_mem),
        .uop_wr_mem        (uop_wr_mem),
        .uop_cond_branch   (uop_cond_branch),
        .uop_uncond_branch (uop_uncond_branch),
        .uop_csr_op        (uop_csr_op),
        .uop_halt          (uop_halt),
        .uop_illegal       (uop_illegal),
        .uop_has_dest      (uop_has_dest),
        .uop_src1_tag      (uop_src1_tag),
        .uop_src2_tag      (uop_src2_tag),
        .uop_dest_tag      (uop_dest_tag),
        .uop_old_tag       (uop_old_tag)
    );

    always #20 clk = ~clk;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        fail_run($sformatf("MISMATCH at %0d ns: %s", $time, msg));
    endtask

    task automatic load_stim();
        int          fd;
        int          n;
        string       text;
        logic [31:0] word, addr;
        logic [7:0]  opa, opb, alu, flags;
        int          k;
        fd = $fopen("test/rename_stim.txt", "r");
        if (fd == 0) begin
            fail_run("Cannot open the stimulus file test/rename_stim.txt");
        end
        while (!$feof(fd)) begin
            text = "";
            n = $fgets(text, fd);
            word  = '0;
            addr  = '0;
            opa   = '0;
            opb   = '0;
            alu   = '0;
            flags = '0;
            k     = 0;
            if (n > 0 && text[0] == "I") begin
                n = $sscanf(text, "I %h %h %h %h %h %h", word, addr, opa, opb, alu, flags);
                if (n != 6) begin
                    fail_run({"Malformed instruction line in stimulus: ", text});
                end
                num_inst++;
            end else if (n > 0 && text[0] == "C") begin
                n = $sscanf(text, "C %d", k);
                if (n != 1) begin
                    fail_run({"Malformed commit line in stimulus: ", text});
                end
            end else begin
                continue;
            end
            s_kind.push_back(text[0]);
            s_inst.push_back(word);
            s_pc.push_back(addr);
            s_opa.push_back(opa);
            s_opb.push_back(opb);
            s_alu.push_back(alu);
            s_flags.push_back(flags);
            s_k.push_back(k);
        end
        $fclose(fd);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Output checking against the model
    //////////////////////////////////////////////////////////////////////
    task automatic check_uop();
        int                    idx;
        logic [4:0]            rs1, rs2, rd;
        logic                  need_rs1, need_rs2, alloc;
        logic [15:0]           got_ctl, exp_ctl;
        rename_pkg::phys_tag_t exp_src1, exp_src2, exp_dest, exp_old;
        assert (pending.size() > 0)
            else report_mismatch("micro-op appeared with no instruction outstanding");
        idx = pending.pop_front();
        received++;
        rs1 = s_inst[idx][19:15];
        rs2 = s_inst[idx][24:20];
        rd  = s_inst[idx][11:7];

        assert (uop_pc == s_pc[idx])
            else report_mismatch($sformatf("entry %0d pc %h, expected %h",
                                           idx, uop_pc, s_pc[idx]));
        // Stim column order with has_dest left out
        got_ctl = {uop_opa_select, uop_opb_select, uop_alu_func, uop_rd_mem, uop_wr_mem,
                   uop_cond_branch, uop_uncond_branch, uop_csr_op, uop_halt, uop_illegal};
        exp_ctl = {s_opa[idx][1:0], s_opb[idx][2:0], s_alu[idx][3:0], s_flags[idx][6:0]};
        assert (got_ctl == exp_ctl)
            else report_mismatch($sformatf("entry %0d control %h, expected %h",
                                           idx, got_ctl, exp_ctl));

        need_rs1 = s_opa[idx] == rename_pkg::OPA_IS_RS1 || s_flags[idx][4];
        need_rs2 = s_opb[idx] == rename_pkg::OPB_IS_RS2 ||
                   s_opb[idx] == rename_pkg::OPB_IS_S_IMM ||
                   s_opb[idx] == rename_pkg::OPB_IS_B_IMM;
        alloc    = s_flags[idx][7] && rd != 5'd0;
        exp_src1 = need_rs1 ? model_map[rs1] : '0;
        exp_src2 = need_rs2 ? model_map[rs2] : '0;
        exp_dest = '0;
        exp_old  = '0;
        if (alloc) begin
            assert (model_free.size() > 0)
                else report_mismatch($sformatf("entry %0d took a tag while none was free", idx));
            exp_dest = model_free.pop_front();
            exp_old  = model_map[rd];
            model_map[rd] = exp_dest;
            old_seen.push_back(exp_old);
        end

        assert (uop_has_dest == alloc)
            else report_mismatch($sformatf("entry %0d has_dest %b, expected %b",
                                           idx, uop_has_dest, alloc));
        assert (uop_src1_tag == exp_src1)
            else report_mismatch($sformatf("entry %0d src1 tag %0d, expected %0d",
                                           idx, uop_src1_tag, exp_src1));
        assert (uop_src2_tag == exp_src2)
            else report_mismatch($sformatf("entry %0d src2 tag %0d, expected %0d",
                                           idx, uop_src2_tag, exp_src2));
        assert (uop_dest_tag == exp_dest)
            else report_mismatch($sformatf("entry %0d dest tag %0d, expected %0d",
                                           idx, uop_dest_tag, exp_dest));
        assert (uop_old_tag == exp_old)
            else report_mismatch($sformatf("entry %0d old tag %0d, expected %0d",
                                           idx, uop_old_tag, exp_old));
    endtask

    // Offer one instruction and hold it until the DUT takes it
    task automatic offer_inst(input int idx);
        logic taken;
        inst_valid = 1'b1;
        inst       = s_inst[idx];
        pc         = s_pc[idx];
        pending.push_back(idx);
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = inst_ready;
            @(posedge clk);
        end
        #2;
        inst_valid = 1'b0;
    endtask

    // Returns the k-th old tag once the DUT has reported it
    task automatic return_old_tag(input int k);
        while (old_seen.size() <= k) begin
            @(posedge clk);
            #2;
        end
        commit_valid = 1'b1;
        commit_tag   = old_seen[k];
        model_free.push_back(old_seen[k]);
        @(posedge clk);
        #2;
        commit_valid = 1'b0;
    endtask

    always @(negedge clk) begin
        if (uop_valid && uop_ready) begin
            check_uop();
        end
    end

    always @(posedge clk) begin
        #2;
        uop_ready = ($random(seed) & 3) != 0;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            fail_run($sformatf("Timeout: run did not finish within %0d cycles", limit));
        end
    end

    initial begin
        int i;
        clk          = 1'b0;
        rst_n        = 1'b0;
        inst_valid   = 1'b0;
        inst         = '0;
        pc           = '0;
        commit_valid = 1'b0;
        commit_tag   = '0;
        uop_ready    = 1'b0;
        // Identity map and tags 32 and up free as after reset
        for (i = 0; i < rename_pkg::ARCH_REGS; i++) begin
            model_map[i] = rename_pkg::phys_tag_t'(i);
        end
        for (i = rename_pkg::ARCH_REGS; i < PHYS_REGS; i++) begin
            model_free.push_back(rename_pkg::phys_tag_t'(i));
        end
        load_stim();
        limit = 20 * s_kind.size() + 100;

        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        assert (!uop_valid && inst_ready)
            else report_mismatch("pipeline not idle after reset");

        for (i = 0; i < s_kind.size(); i++) begin
            if (s_kind[i] == "I") begin
                offer_inst(i);
            end else begin
                return_old_tag(s_k[i]);
            end
        end
        while (received < num_inst) begin
            @(posedge clk);
        end
        // Idle cycles catch a repeated micro-op
        repeat (4) @(posedge clk);
        if (pending.size() == 0 && received == num_inst) begin
            $display("All checks passed");
            $finish;
        end else begin
            report_mismatch($sformatf("%0d micro-ops received, expected %0d",
                                      received, num_inst));
        end
    end

endmodule

`default_nettype wire

// File: verilog.f
src/rename_pkg.sv
src/rv32_decoder.sv
src/decode_stage.sv
src/map_table.sv
src/free_list.sv
src/rename_stage.sv
src/rename_top.sv
test/tb_rename.sv

// File: test/rename_stim.txt
# I <inst> <pc> <opa> <opb> <alu> <flags: has_dest rd_mem wr_mem cond uncond csr halt illegal>
# C <k>  commit the k-th old tag returned so far, counted from 0
I 123450b7 00001000 2 4 0 80
I 00001117 00001004 1 4 0 80
I 008001ef 00001008 1 5 0 88
I 00008067 0000100c 0 1 0 88
I 00208863 00001010 1 3 0 10
I 00812203 00001014 0 1 0 c0
I 0040a623 00001018 0 2 0 20
I fff20293 0000101c 0 1 0 80
I 4032d313 00001020 0 1 9 80
I 401303b3 00001024 0 0 1 80
I 0223a433 00001028 0 0 c 80
I 300094f3 0000102c 0 0 0 04
I 00208033 00001030 0 0 0 80
I ffffffff 00001034 0 0 0 01
I 0041c533 00001038 0 0 6 80
C 1
C 3
I 02a505b3 0000103c 0 0 a 80
I 0255b633 00001040 0 0 d 80
C 9
I 10500073 00001044 0 0 0 02
I fe746ee3 00001048 1 3 0 10
I 0220c733 0000104c 0 0 0 01
C 10
I 00004683 00001050 0 1 0 c0
